// File: hdl/mgmt_pkg.sv
package mgmt_pkg;

	////////////////////////////////////////
	// Bus and field widths

	localparam int ADDR_W     = 16;
	localparam int DATA_W     = 8;
	localparam int PORT_BITS  = 4;
	localparam int REGID_BITS = 10;
	localparam int VLAN_W     = 12;
	localparam int PHY_ADDR_W = 5;

	////////////////////////////////////////
	// Address map

	// Device information, big-endian
	localparam logic [ADDR_W-1:0] REG_IDCODE_BASE  = 16'h0000;
	localparam int                REG_IDCODE_BYTES = 4;
	localparam logic [ADDR_W-1:0] REG_SERIAL_BASE  = 16'h0004;
	localparam int                REG_SERIAL_BYTES = 8;

	// Six 16-bit sensors, little-endian
	localparam logic [ADDR_W-1:0] REG_SENSOR_BASE  = 16'h0010;
	localparam int                REG_SENSOR_BYTES = 12;

	// MDIO banks, one 4-byte window per channel
	localparam logic [ADDR_W-1:0] REG_MDIO_BASE    = 16'h0048;
	localparam int                REG_MDIO_STRIDE  = 4;

	// Everything from here up is per-port space
	localparam logic [ADDR_W-1:0] REG_INTERFACE_BASE = 16'h4000;

	// Offsets inside one port block
	localparam logic [3:0] IF_VLAN_LO  = 4'h0;
	localparam logic [3:0] IF_VLAN_HI  = 4'h1;
	localparam logic [3:0] IF_TAG_MODE = 4'h2;

	////////////////////////////////////////
	// Address views

	// Port space split: 2 top bits, port number, register offset
	typedef struct packed {
		logic [1:0]            top;
		logic [PORT_BITS-1:0]  port;
		logic [REGID_BITS-1:0] regid;
	} port_addr_t;

	typedef union packed {
		logic [ADDR_W-1:0] regnum;
		port_addr_t        port_view;
	} mgmt_addr_u;

	typedef enum logic [2:0] {
		REGION_NONE,
		REGION_IDCODE,
		REGION_SERIAL,
		REGION_SENSOR,
		REGION_MDIO,
		REGION_PORT
	} region_e;

	// One decoded access, channel or port in index
	typedef struct packed {
		logic                 en;
		region_e              region;
		logic [PORT_BITS-1:0] index;
		logic [3:0]           offset;
		logic [DATA_W-1:0]    data;
	} bus_req_t;

	////////////////////////////////////////
	// Payload bundles

	typedef struct packed {
		logic [31:0] idcode;
		logic        idcode_valid;
		logic [63:0] serial;
		logic        serial_valid;
	} dev_info_t;

	typedef struct packed {
		logic [15:0] fan0_rpm;
		logic [15:0] fan1_rpm;
		logic [15:0] die_temp;
		logic [15:0] volt_core;
		logic [15:0] volt_ram;
		logic [15:0] volt_aux;
	} sensor_t;

	typedef struct packed {
		logic [PHY_ADDR_W-1:0] reg_addr;
		logic [PHY_ADDR_W-1:0] phy_addr;
		logic [15:0]           wr_data;
		logic                  reg_rd;
		logic                  reg_wr;
	} mdio_cmd_t;

	typedef struct packed {
		logic        busy;
		logic [15:0] rd_data;
	} mdio_stat_t;

	typedef struct packed {
		logic [VLAN_W-1:0] vlan;
		logic              tagged_allowed;
		logic              untagged_allowed;
		logic              is_trunk;
	} port_cfg_t;

endpackage

// File: hdl/mgmt_addr_decode.sv
`timescale 1ns/10ps

module mgmt_addr_decode #(
	parameter int NUM_PORTS = 4,
	parameter int NUM_MDIO  = 3
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           rd_en,
	input  mgmt_pkg::mgmt_addr_u           rd_addr,
	input  logic                           wr_en,
	input  mgmt_pkg::mgmt_addr_u           wr_addr,
	input  logic [mgmt_pkg::DATA_W-1:0]    wr_data,
	output mgmt_pkg::bus_req_t             rd_req,
	output mgmt_pkg::bus_req_t             wr_req
);

	// Map one address onto a region, an index and a byte offset
	function automatic mgmt_pkg::bus_req_t classify(
		input logic                        en,
		input mgmt_pkg::mgmt_addr_u        addr,
		input logic [mgmt_pkg::DATA_W-1:0] data
	);
		mgmt_pkg::bus_req_t              req;
		logic [mgmt_pkg::ADDR_W-1:0]     rel;
		req        = '0;
		req.en     = en;
		req.data   = data;
		req.region = mgmt_pkg::REGION_NONE;
		rel        = addr.regnum - mgmt_pkg::REG_MDIO_BASE;

		// Port space, only the low 16 offsets of a block are decoded
		if (addr.regnum >= mgmt_pkg::REG_INTERFACE_BASE) begin
			if ((addr.port_view.port < NUM_PORTS) &&
				(addr.port_view.regid[mgmt_pkg::REGID_BITS-1:4] == '0)) begin
				req.region = mgmt_pkg::REGION_PORT;
				req.index  = addr.port_view.port;
				req.offset = addr.port_view.regid[3:0];
			end
		end
		else if (addr.regnum < mgmt_pkg::REG_IDCODE_BASE + mgmt_pkg::REG_IDCODE_BYTES) begin
			req.region = mgmt_pkg::REGION_IDCODE;
			req.offset = 4'(addr.regnum - mgmt_pkg::REG_IDCODE_BASE);
		end
		else if (addr.regnum >= mgmt_pkg::REG_SERIAL_BASE &&
			addr.regnum < mgmt_pkg::REG_SERIAL_BASE + mgmt_pkg::REG_SERIAL_BYTES) begin
			req.region = mgmt_pkg::REGION_SERIAL;
			req.offset = 4'(addr.regnum - mgmt_pkg::REG_SERIAL_BASE);
		end
		else if (addr.regnum >= mgmt_pkg::REG_SENSOR_BASE &&
			addr.regnum < mgmt_pkg::REG_SENSOR_BASE + mgmt_pkg::REG_SENSOR_BYTES) begin
			req.region = mgmt_pkg::REGION_SENSOR;
			req.offset = 4'(addr.regnum - mgmt_pkg::REG_SENSOR_BASE);
		end
		// Channels past NUM_MDIO fall through as unmapped
		else if (addr.regnum >= mgmt_pkg::REG_MDIO_BASE &&
			addr.regnum < mgmt_pkg::REG_MDIO_BASE + mgmt_pkg::REG_MDIO_STRIDE * NUM_MDIO) begin
			req.region = mgmt_pkg::REGION_MDIO;
			req.index  = 4'(rel >> 2);
			req.offset = {2'b00, rel[1:0]};
		end
		return req;
	endfunction

	// Pure decode, no register on either side
	assign rd_req = classify(rd_en, rd_addr, '0);
	assign wr_req = classify(wr_en, wr_addr, wr_data);

	// Host bus rule, one direction per cycle
	assert property (@(posedge clk) disable iff (!rst_n) !(rd_en && wr_en))
		else $error("rd_en and wr_en high together");

endmodule

// File: hdl/mgmt_mdio_regs.sv
`timescale 1ns/10ps

module mgmt_mdio_regs #(
	parameter int NUM_MDIO = 3
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  mgmt_pkg::bus_req_t           wr_req,
	input  mgmt_pkg::bus_req_t           rd_req,
	input  mgmt_pkg::mdio_stat_t         mdio_stat [NUM_MDIO],
	output mgmt_pkg::mdio_cmd_t          mdio_cmd [NUM_MDIO],
	output logic [mgmt_pkg::DATA_W-1:0]  mdio_rd_byte
);

	// Channel hit for a write and for an offset 0 read
	logic [NUM_MDIO-1:0] wr_sel;
	logic [NUM_MDIO-1:0] rd_sel;

	// Busy as seen at the last offset 0 read
	logic [NUM_MDIO-1:0] busy_latched;

	////////////////////////////////////////
	// One register bank per channel

	for (genvar g = 0; g < NUM_MDIO; g++) begin : g_chan

		assign wr_sel[g] = wr_req.en && (wr_req.region == mgmt_pkg::REGION_MDIO) &&
			(wr_req.index == 4'(g));
		assign rd_sel[g] = rd_req.en && (rd_req.region == mgmt_pkg::REGION_MDIO) &&
			(rd_req.index == 4'(g)) && (rd_req.offset == 4'h0);

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				mdio_cmd[g]     <= '0;
				busy_latched[g] <= 1'b0;
			end
			else begin
				// Strobes drop unless rewritten this cycle
				mdio_cmd[g].reg_rd <= 1'b0;
				mdio_cmd[g].reg_wr <= 1'b0;

				if (wr_sel[g]) begin
					case (wr_req.offset[1:0])
						2'd0: mdio_cmd[g].wr_data[7:0]  <= wr_req.data;
						2'd1: mdio_cmd[g].wr_data[15:8] <= wr_req.data;
						2'd2: begin
							mdio_cmd[g].reg_addr      <= wr_req.data[4:0];
							mdio_cmd[g].phy_addr[2:0] <= wr_req.data[7:5];
						end
						// PHY address top bits plus the command strobes
						2'd3: begin
							mdio_cmd[g].phy_addr[4:3] <= wr_req.data[1:0];
							mdio_cmd[g].reg_rd        <= wr_req.data[5];
							mdio_cmd[g].reg_wr        <= wr_req.data[6];
						end
						default: ;
					endcase
				end

				// Snapshot busy together with the low data byte
				if (rd_sel[g])
					busy_latched[g] <= mdio_stat[g].busy;
			end
		end

		// Each strobe is a single-cycle pulse
		assert property (@(posedge clk) disable iff (!rst_n)
			mdio_cmd[g].reg_rd |=> !mdio_cmd[g].reg_rd)
			else $error("reg_rd longer than one cycle on channel %0d", g);
		assert property (@(posedge clk) disable iff (!rst_n)
			mdio_cmd[g].reg_wr |=> !mdio_cmd[g].reg_wr)
			else $error("reg_wr longer than one cycle on channel %0d", g);
	end

	////////////////////////////////////////
	// Read byte of the addressed channel

	always_comb begin
		mdio_rd_byte = '0;
		for (int i = 0; i < NUM_MDIO; i++) begin
			if (rd_req.index == 4'(i)) begin
				case (rd_req.offset[1:0])
					2'd0:    mdio_rd_byte = mdio_stat[i].rd_data[7:0];
					2'd1:    mdio_rd_byte = mdio_stat[i].rd_data[15:8];
					2'd3:    mdio_rd_byte = {busy_latched[i], 7'b0};
					default: mdio_rd_byte = '0;
				endcase
			end
		end
	end

endmodule

// File: hdl/mgmt_port_cfg.sv
`timescale 1ns/10ps

module mgmt_port_cfg #(
	parameter int NUM_PORTS = 4
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  mgmt_pkg::bus_req_t   wr_req,
	output mgmt_pkg::port_cfg_t  port_cfg [NUM_PORTS]
);

	// Write hit per port
	logic [NUM_PORTS-1:0] wr_sel;

	////////////////////////////////////////
	// Per-port configuration

	for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port

		assign wr_sel[g] = wr_req.en && (wr_req.region == mgmt_pkg::REGION_PORT) &&
			(wr_req.index == 4'(g));

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				port_cfg[g] <= '0;
			end
			else if (wr_sel[g]) begin
				case (wr_req.offset)
					// VLAN number, low byte then the top nibble
					mgmt_pkg::IF_VLAN_LO:
						port_cfg[g].vlan[7:0] <= wr_req.data;
					mgmt_pkg::IF_VLAN_HI:
						port_cfg[g].vlan[11:8] <= wr_req.data[3:0];
					// Inbound tag policy and trunk flag
					mgmt_pkg::IF_TAG_MODE: begin
						port_cfg[g].tagged_allowed   <= wr_req.data[0];
						port_cfg[g].untagged_allowed <= wr_req.data[1];
						port_cfg[g].is_trunk         <= wr_req.data[4];
					end
					default: ;
				endcase
			end
		end
	end

	// Decode must already drop ports beyond NUM_PORTS
	assert property (@(posedge clk) disable iff (!rst_n)
		(wr_req.en && wr_req.region == mgmt_pkg::REGION_PORT) |-> (wr_req.index < NUM_PORTS))
		else $error("port write to index %0d out of range", wr_req.index);

endmodule

// File: hdl/mgmt_read_mux.sv
`timescale 1ns/10ps

module mgmt_read_mux (
	input  logic                         clk,
	input  logic                         rst_n,
	input  mgmt_pkg::bus_req_t           rd_req,
	input  mgmt_pkg::dev_info_t          dev_info,
	input  mgmt_pkg::sensor_t            sensors,
	input  logic [mgmt_pkg::DATA_W-1:0]  mdio_rd_byte,
	output logic                         rd_valid,
	output logic [mgmt_pkg::DATA_W-1:0]  rd_data
);

	// Read held over while device info is not yet valid
	logic pending;
	logic active;
	logic stall;

	// Byte positions for the big-endian device fields
	logic [1:0] id_sel;
	logic [2:0] ser_sel;

	// Sensors as one flat word, fan0 in the low bytes
	logic [95:0] sensor_word;

	logic [mgmt_pkg::DATA_W-1:0] sel_byte;

	////////////////////////////////////////
	// Read control

	assign active = rd_req.en || pending;

	// Only the device info regions can stall
	assign stall = ((rd_req.region == mgmt_pkg::REGION_IDCODE) && !dev_info.idcode_valid) ||
		((rd_req.region == mgmt_pkg::REGION_SERIAL) && !dev_info.serial_valid);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending  <= 1'b0;
			rd_valid <= 1'b0;
			rd_data  <= '0;
		end
		else begin
			rd_valid <= 1'b0;
			if (active) begin
				if (stall) begin
					pending <= 1'b1;
				end
				else begin
					// Address is still stable, so capture and finish
					pending  <= 1'b0;
					rd_valid <= 1'b1;
					rd_data  <= sel_byte;
				end
			end
		end
	end

	////////////////////////////////////////
	// Byte select

	assign id_sel  = 2'd3 - rd_req.offset[1:0];
	assign ser_sel = 3'd7 - rd_req.offset[2:0];

	assign sensor_word = {sensors.volt_aux, sensors.volt_ram, sensors.volt_core,
		sensors.die_temp, sensors.fan1_rpm, sensors.fan0_rpm};

	always_comb begin
		case (rd_req.region)
			mgmt_pkg::REGION_IDCODE:
				sel_byte = 8'(dev_info.idcode >> {id_sel, 3'b000});
			mgmt_pkg::REGION_SERIAL:
				sel_byte = 8'(dev_info.serial >> {ser_sel, 3'b000});
			// Low byte of each reading first
			mgmt_pkg::REGION_SENSOR:
				sel_byte = 8'(sensor_word >> {rd_req.offset, 3'b000});
			mgmt_pkg::REGION_MDIO:
				sel_byte = mdio_rd_byte;
			// Port registers and unmapped space read zero
			default:
				sel_byte = '0;
		endcase
	end

	// Every rd_valid pulse closes a read that was started or held
	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(rd_valid) |-> $past(rd_req.en || pending))
		else $error("rd_valid without a read in progress");

endmodule

// File: hdl/mgmt_regs_top.sv
`timescale 1ns/10ps

module mgmt_regs_top #(
	parameter int NUM_PORTS = 4,
	parameter int NUM_MDIO  = 3
) (
	input  logic                         clk,
	input  logic                         rst_n,

	// Host strobe bus
	input  logic                         rd_en,
	input  mgmt_pkg::mgmt_addr_u         rd_addr,
	output logic                         rd_valid,
	output logic [mgmt_pkg::DATA_W-1:0]  rd_data,
	input  logic                         wr_en,
	input  mgmt_pkg::mgmt_addr_u         wr_addr,
	input  logic [mgmt_pkg::DATA_W-1:0]  wr_data,

	// Device information and sensors
	input  mgmt_pkg::dev_info_t          dev_info,
	input  mgmt_pkg::sensor_t            sensors,

	// MDIO controllers
	input  mgmt_pkg::mdio_stat_t         mdio_stat [NUM_MDIO],
	output mgmt_pkg::mdio_cmd_t          mdio_cmd [NUM_MDIO],

	// Port configuration
	output mgmt_pkg::port_cfg_t          port_cfg [NUM_PORTS]
);

	mgmt_pkg::bus_req_t          rd_req;
	mgmt_pkg::bus_req_t          wr_req;
	logic [mgmt_pkg::DATA_W-1:0] mdio_rd_byte;

	////////////////////////////////////////
	// Address decode

	mgmt_addr_decode #(
		.NUM_PORTS (NUM_PORTS),
		.NUM_MDIO  (NUM_MDIO)
	) u_decode (
		.clk     (clk),
		.rst_n   (rst_n),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_req  (rd_req),
		.wr_req  (wr_req)
	);

	////////////////////////////////////////
	// Register banks

	mgmt_mdio_regs #(
		.NUM_MDIO (NUM_MDIO)
	) u_mdio (
		.clk          (clk),
		.rst_n        (rst_n),
		.wr_req       (wr_req),
		.rd_req       (rd_req),
		.mdio_stat    (mdio_stat),
		.mdio_cmd     (mdio_cmd),
		.mdio_rd_byte (mdio_rd_byte)
	);

	mgmt_port_cfg #(
		.NUM_PORTS (NUM_PORTS)
	) u_port (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_req   (wr_req),
		.port_cfg (port_cfg)
	);

	////////////////////////////////////////
	// Read return path

	mgmt_read_mux u_read (
		.clk          (clk),
		.rst_n        (rst_n),
		.rd_req       (rd_req),
		.dev_info     (dev_info),
		.sensors      (sensors),
		.mdio_rd_byte (mdio_rd_byte),
		.rd_valid     (rd_valid),
		.rd_data      (rd_data)
	);

endmodule

// File: verif/tb_mgmt_model.svh
`ifndef TB_MGMT_MODEL_SVH
`define TB_MGMT_MODEL_SVH

////////////////////////////////////////
// Expected read bytes

// IDCODE is big-endian, offset 0 is the top byte
function automatic logic [7:0] idcode_byte(input logic [31:0] idcode, input int off);
	return idcode[(3 - off) * 8 +: 8];
endfunction

// Serial is big-endian over eight bytes
function automatic logic [7:0] serial_byte(input logic [63:0] serial, input int off);
	return serial[(7 - off) * 8 +: 8];
endfunction

// Sensor k at offsets 2k and 2k+1, low byte first
function automatic logic [7:0] sensor_byte(input mgmt_pkg::sensor_t s, input int off);
	logic [15:0] reading;
	case (off / 2)
		0:       reading = s.fan0_rpm;
		1:       reading = s.fan1_rpm;
		2:       reading = s.die_temp;
		3:       reading = s.volt_core;
		4:       reading = s.volt_ram;
		default: reading = s.volt_aux;
	endcase
	return (off % 2 == 1) ? reading[15:8] : reading[7:0];
endfunction

// PHY data low and high, a zero byte, then busy in bit 7
function automatic logic [7:0] mdio_byte(input logic [15:0] data, input logic busy,
	input int off);
	case (off)
		0:       return data[7:0];
		1:       return data[15:8];
		3:       return {busy, 7'b0};
		default: return 8'h00;
	endcase
endfunction

////////////////////////////////////////
// Expected register state after a write

// Strobes only live for the cycle after a byte 3 write
function automatic mgmt_pkg::mdio_cmd_t apply_mdio_write(input mgmt_pkg::mdio_cmd_t cmd,
	input int off, input logic [7:0] data);
	mgmt_pkg::mdio_cmd_t upd;
	upd        = cmd;
	upd.reg_rd = 1'b0;
	upd.reg_wr = 1'b0;
	case (off)
		0: upd.wr_data[7:0]  = data;
		1: upd.wr_data[15:8] = data;
		2: begin
			upd.reg_addr      = data[4:0];
			upd.phy_addr[2:0] = data[7:5];
		end
		3: begin
			upd.phy_addr[4:3] = data[1:0];
			upd.reg_rd        = data[5];
			upd.reg_wr        = data[6];
		end
		default: ;
	endcase
	return upd;
endfunction

// VLAN halves and tag mode bits of one port
function automatic mgmt_pkg::port_cfg_t apply_port_write(input mgmt_pkg::port_cfg_t cfg,
	input int off, input logic [7:0] data);
	mgmt_pkg::port_cfg_t upd;
	upd = cfg;
	case (off)
		0: upd.vlan[7:0]  = data;
		1: upd.vlan[11:8] = data[3:0];
		2: begin
			upd.tagged_allowed   = data[0];
			upd.untagged_allowed = data[1];
			upd.is_trunk         = data[4];
		end
		default: ;
	endcase
	return upd;
endfunction

`endif

// File: verif/tb_mgmt_regs.sv
`timescale 1ns/10ps

module tb_mgmt_regs;

	localparam int NUM_PORTS    = 4;
	localparam int NUM_MDIO     = 3;
	localparam int CLK_NS       = 8;
	localparam int RESET_CYCLES = 5;
	// Reads, writes and strobe checks over all tests rounded up
	localparam int NUM_OPS      = 95;

	logic                 clk;
	logic                 rst_n;
	logic                 rd_en;
	mgmt_pkg::mgmt_addr_u rd_addr;
	logic                 rd_valid;
	logic [7:0]           rd_data;
	logic                 wr_en;
	mgmt_pkg::mgmt_addr_u wr_addr;
	logic [7:0]           wr_data;
	mgmt_pkg::dev_info_t  dev_info;
	mgmt_pkg::sensor_t    sensors;
	mgmt_pkg::mdio_stat_t mdio_stat [NUM_MDIO];
	mgmt_pkg::mdio_cmd_t  mdio_cmd [NUM_MDIO];
	mgmt_pkg::port_cfg_t  port_cfg [NUM_PORTS];

	// Expected read bytes in issue order
	logic [7:0]           exp_q [$];
	mgmt_pkg::mdio_cmd_t  mdio_model [NUM_MDIO];
	mgmt_pkg::port_cfg_t  port_model [NUM_PORTS];

	`include "tb_mgmt_model.svh"

	mgmt_regs_top dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.dev_info  (dev_info),
		.sensors   (sensors),
		.mdio_stat (mdio_stat),
		.mdio_cmd  (mdio_cmd),
		.port_cfg  (port_cfg)
	);

	always #4 clk = ~clk;

	////////////////////////////////////////
	// Error handling and checks

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// Every rd_valid pulse retires the oldest expected byte
	always @(negedge clk) begin
		if (rst_n && rd_valid) begin
			if (exp_q.size() == 0)
				abort_run("rd_valid pulsed with no read outstanding");
			else
				check_value("rd_data", rd_data, exp_q.pop_front());
		end
	end

	// Run length bound from the operation count
	initial begin
		#(NUM_OPS * 40 * CLK_NS + RESET_CYCLES * CLK_NS);
		abort_run("watchdog expired before the tests finished");
	end

	////////////////////////////////////////
	// Bus tasks

	task automatic write_byte(input logic [15:0] addr, input logic [7:0] data);
		@(negedge clk);
		wr_en          = 1'b1;
		wr_addr.regnum = addr;
		wr_data        = data;
		@(negedge clk);
		wr_en          = 1'b0;
	endtask

	// which picks the level held low (1 idcode_valid, 2 serial_valid, 0 none)
	task automatic read_byte(input logic [15:0] addr, input logic [7:0] exp,
		input int hold, input int which);
		int cyc;
		int hi_cyc;
		bit seen;
		@(negedge clk);
		if (which == 1)
			dev_info.idcode_valid = 1'b0;
		if (which == 2)
			dev_info.serial_valid = 1'b0;
		rd_en          = 1'b1;
		rd_addr.regnum = addr;
		exp_q.push_back(exp);
		cyc    = 0;
		hi_cyc = 0;
		seen   = 1'b0;
		while (!seen) begin
			@(negedge clk);
			rd_en = 1'b0;
			cyc++;
			if (rd_valid) begin
				seen = 1'b1;
				if (which != 0 && cyc <= hold)
					abort_run($sformatf("rd_valid at 0x%04h while device valid was low", addr));
			end
			else begin
				// Valid level goes high after the hold time
				if (which == 1 && cyc == hold)
					dev_info.idcode_valid = 1'b1;
				if (which == 2 && cyc == hold)
					dev_info.serial_valid = 1'b1;
				if (which == 0 || cyc > hold)
					hi_cyc++;
				if (hi_cyc > 20)
					abort_run($sformatf("read of 0x%04h got no rd_valid within 20 cycles", addr));
			end
		end
		check_value("rd_latency", cyc, (which != 0) ? hold + 1 : 1);
	endtask

	function automatic logic [15:0] port_addr(input int port, input int off);
		return 16'h4000 | (16'(port) << 10) | 16'(off);
	endfunction

	////////////////////////////////////////
	// Test sequence

	initial begin
		logic [15:0] base;
		logic [7:0]  b [4];
		int          p;
		int          off;
		logic [7:0]  d;
		void'($urandom(10342));
		clk      = 1'b0;
		rst_n    = 1'b0;
		rd_en    = 1'b0;
		rd_addr  = '0;
		wr_en    = 1'b0;
		wr_addr  = '0;
		wr_data  = '0;
		dev_info = '0;
		dev_info.idcode_valid = 1'b1;
		dev_info.serial_valid = 1'b1;
		sensors  = '0;
		for (int i = 0; i < NUM_MDIO; i++) begin
			mdio_stat[i]  = '0;
			mdio_model[i] = '0;
		end
		for (int i = 0; i < NUM_PORTS; i++)
			port_model[i] = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;

		// Reset state
		check_value("rd_valid", rd_valid, 0);
		check_value("rd_data", rd_data, 0);
		for (int i = 0; i < NUM_MDIO; i++)
			check_value($sformatf("mdio_cmd[%0d]", i), mdio_cmd[i], 0);
		for (int i = 0; i < NUM_PORTS; i++)
			check_value($sformatf("port_cfg[%0d]", i), port_cfg[i], 0);

		// Device information reads big-endian behind a random stall
		dev_info.idcode = $urandom;
		dev_info.serial = {$urandom, $urandom};
		for (int i = 0; i < 4; i++)
			read_byte(16'h0000 + 16'(i), idcode_byte(dev_info.idcode, i), 1 + $urandom % 6, 1);
		for (int i = 0; i < 8; i++)
			read_byte(16'h0004 + 16'(i), serial_byte(dev_info.serial, i), 1 + $urandom % 6, 2);
		read_byte(16'h0002, idcode_byte(dev_info.idcode, 2), 0, 0);

		// Sensor readings come back little-endian
		sensors = {$urandom, $urandom, $urandom};
		for (int i = 0; i < 12; i++)
			read_byte(16'h0010 + 16'(i), sensor_byte(sensors, i), 0, 0);

		// MDIO commands with at least one strobe kind per channel
		for (int ch = 0; ch < NUM_MDIO; ch++) begin
			base = 16'h0048 + 16'(ch * 4);
			for (int i = 0; i < 4; i++)
				b[i] = 8'($urandom);
			b[3][5] = (ch != 1);
			b[3][6] = (ch != 0);
			for (int i = 0; i < 4; i++) begin
				write_byte(base + 16'(i), b[i]);
				mdio_model[ch] = apply_mdio_write(mdio_model[ch], i, b[i]);
				for (int k = 0; k < NUM_MDIO; k++)
					check_value($sformatf("mdio_cmd[%0d]", k), mdio_cmd[k], mdio_model[k]);
			end
			// Strobes gone one cycle later
			@(negedge clk);
			mdio_model[ch].reg_rd = 1'b0;
			mdio_model[ch].reg_wr = 1'b0;
			check_value($sformatf("mdio_cmd[%0d]", ch), mdio_cmd[ch], mdio_model[ch]);
		end

		// MDIO readback with busy latched at the offset 0 read
		for (int ch = 0; ch < NUM_MDIO; ch++) begin
			base = 16'h0048 + 16'(ch * 4);
			mdio_stat[ch].rd_data = 16'($urandom);
			mdio_stat[ch].busy    = 1'b1;
			read_byte(base, mdio_byte(mdio_stat[ch].rd_data, 1'b1, 0), 0, 0);
			mdio_stat[ch].busy    = 1'b0;
			for (int i = 1; i < 4; i++)
				read_byte(base + 16'(i), mdio_byte(mdio_stat[ch].rd_data, 1'b1, i), 0, 0);
			read_byte(base, mdio_byte(mdio_stat[ch].rd_data, 1'b0, 0), 0, 0);
			read_byte(base + 16'd3, mdio_byte(mdio_stat[ch].rd_data, 1'b0, 3), 0, 0);
		end

		// Port configuration writes where ports 4 and 5 do not exist
		for (int n = 0; n < 24; n++) begin
			p   = $urandom % 6;
			off = $urandom % 3;
			d   = 8'($urandom);
			write_byte(port_addr(p, off), d);
			if (p < NUM_PORTS)
				port_model[p] = apply_port_write(port_model[p], off, d);
			for (int k = 0; k < NUM_PORTS; k++)
				check_value($sformatf("port_cfg[%0d]", k), port_cfg[k], port_model[k]);
		end

		// Port space and holes in the map read zero
		read_byte(port_addr(0, 0), 8'h00, 0, 0);
		read_byte(port_addr(1, 1), 8'h00, 0, 0);
		read_byte(port_addr(2, 2), 8'h00, 0, 0);
		read_byte(16'h000C, 8'h00, 0, 0);
		read_byte(16'h0020, 8'h00, 0, 0);
		read_byte(16'h0054, 8'h00, 0, 0);
		read_byte(16'h3FFF, 8'h00, 0, 0);

		// Stray rd_valid pulses after the last read still reach the compare process
		repeat (2) @(negedge clk);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: sim.f
+incdir+verif
hdl/mgmt_pkg.sv
hdl/mgmt_addr_decode.sv
hdl/mgmt_mdio_regs.sv
hdl/mgmt_port_cfg.sv
hdl/mgmt_read_mux.sv
hdl/mgmt_regs_top.sv
verif/tb_mgmt_regs.sv

// File: Makefile
TOP := tb_mgmt_regs
LOG := sim.log

.PHONY: all compile run clean

all: run

# Testbench and RTL built into one executable under obj_dir
compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f -o $(TOP)

# The run passes only when the log holds the pass line
run: compile
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
